/* vlog.f */
common/rom_pkg.sv
design/rom_client_map.sv
romrq/bank_romrq.sv
design/sdram_rd_arbiter.sv
design/rom_sdram_top.sv
dv/sdram_rd_model.sv
dv/tb_rom_sdram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ROM fetch testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rom_sdram \
    -f vlog.f \
    -o tb_rom_sdram \
    && ./obj_dir/tb_rom_sdram > "$log" 2>&1 \
    || echo "Build or run failed, see $log"

[ -f "$log" ] && cat "$log"
grep -qx "Simulation finished: PASS" "$log" \
    && { echo "Result: passed"; exit 0; } \
    || { echo "Result: failed"; exit 1; }

/* dv/tb_rom_sdram.sv */
// Testbench for the ROM fetch top: clock, reset, client reads, checking assertions, watchdog
`timescale 1ns/10ps

module tb_rom_sdram;

    localparam int mix_rounds      = 32;
    localparam int total_reqs      = 8 + 5 + 8 + 4 * mix_rounds;
    localparam int req_cycles      = 4 * 12 + 8;    // Four queued transfers plus slack
    localparam int watchdog_cycles = total_reqs * req_cycles + 50;

    logic clk = 1'b0;
    logic rst;
    logic main_rom_cs, snd_cs, rom0_cs, rom1_cs;
    logic [20:0] main_rom_addr;
    logic [15:0] snd_addr;
    logic [19:0] rom0_addr, rom1_addr;
    logic rom0_half, rom1_half;
    logic [15:0] main_rom_data;
    logic [ 7:0] snd_data;
    logic [31:0] rom0_data, rom1_data;
    logic main_rom_ok, snd_ok, rom0_ok, rom1_ok;
    logic [21:0] sdram_addr;
    logic sdram_rd, sdram_ack, sdram_rdy;
    logic [31:0] data_read;

    // Client address one cycle back, which the returned data belongs to
    logic [20:0] main_addr_q;
    logic [15:0] snd_addr_q;
    logic [19:0] rom0_addr_q, rom1_addr_q;
    logic rom0_half_q, rom1_half_q;
    logic [15:0] exp_main, snd_word;
    logic [ 7:0] exp_snd;
    logic [31:0] exp_rom0, exp_rom1;
    logic [21:0] line_main, line_snd, line_rom0, line_rom1;
    logic cs_seen, xfer_open, expect_hit;
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    rom_sdram_top dut0 (.*);

    sdram_rd_model u_mem (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sdram_addr ( sdram_addr ),
        .sdram_rd   ( sdram_rd   ),
        .sdram_ack  ( sdram_ack  ),
        .sdram_rdy  ( sdram_rdy  ),
        .data_read  ( data_read  )
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] rom_word(input logic [21:0] a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    // Line at an even word address, next word in the high half
    function automatic logic [31:0] rom_line(input logic [21:0] a);
        return {rom_word(a + 22'd1), rom_word(a)};
    endfunction

    always @(posedge clk) begin
        main_addr_q <= main_rom_addr;
        snd_addr_q  <= snd_addr;
        rom0_addr_q <= rom0_addr;
        rom0_half_q <= rom0_half;
        rom1_addr_q <= rom1_addr;
        rom1_half_q <= rom1_half;
    end

    assign exp_main = rom_word(rom_pkg::main_offset + {1'b0, main_addr_q});
    assign snd_word = rom_word(rom_pkg::snd_offset + {7'd0, snd_addr_q[15:1]});
    assign exp_snd  = snd_addr_q[0] ? snd_word[15:8] : snd_word[7:0];  // Byte 0 is LSB
    assign exp_rom0 = rom_line(rom_pkg::obj_offset + {rom0_addr_q, rom0_half_q, 1'b0});
    assign exp_rom1 = rom_line(rom_pkg::scr_offset + {rom1_addr_q, rom1_half_q, 1'b0});

    // Region line address each selecting client may put on the SDRAM port
    assign line_main = rom_pkg::main_offset + ({1'b0, main_rom_addr} & ~22'd1);
    assign line_snd  = rom_pkg::snd_offset + ({7'd0, snd_addr[15:1]} & ~22'd1);
    assign line_rom0 = rom_pkg::obj_offset + {rom0_addr, rom0_half, 1'b0};
    assign line_rom1 = rom_pkg::scr_offset + {rom1_addr, rom1_half, 1'b0};

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_seen   <= 1'b0;
            xfer_open <= 1'b0;
        end else begin
            cs_seen <= cs_seen | main_rom_cs | snd_cs | rom0_cs | rom1_cs;
            if (sdram_rdy) xfer_open <= 1'b0;
            else if (sdram_rd) xfer_open <= 1'b1;   // Open from request to data
        end
    end

    a_main_data: assert property (@(posedge clk) disable iff (rst)
        main_rom_ok |-> main_rom_data == exp_main)
        else begin
            $display("Mismatch main_rom_data: got 0x%h, expected 0x%h",
                     $sampled(main_rom_data), $sampled(exp_main));
            errors++;
        end

    a_snd_data: assert property (@(posedge clk) disable iff (rst)
        snd_ok |-> snd_data == exp_snd)
        else begin
            $display("Mismatch snd_data: got 0x%h, expected 0x%h",
                     $sampled(snd_data), $sampled(exp_snd));
            errors++;
        end

    a_rom0_data: assert property (@(posedge clk) disable iff (rst)
        rom0_ok |-> rom0_data == exp_rom0)
        else begin
            $display("Mismatch rom0_data: got 0x%h, expected 0x%h",
                     $sampled(rom0_data), $sampled(exp_rom0));
            errors++;
        end

    a_rom1_data: assert property (@(posedge clk) disable iff (rst)
        rom1_ok |-> rom1_data == exp_rom1)
        else begin
            $display("Mismatch rom1_data: got 0x%h, expected 0x%h",
                     $sampled(rom1_data), $sampled(exp_rom1));
            errors++;
        end

    // Region offsets sit above the bits that the data pattern shows
    a_sdram_addr: assert property (@(posedge clk) disable iff (rst)
        sdram_rd |-> (main_rom_cs && sdram_addr == line_main)
                  || (snd_cs && sdram_addr == line_snd)
                  || (rom0_cs && sdram_addr == line_rom0)
                  || (rom1_cs && sdram_addr == line_rom1))
        else begin
            $display("Mismatch sdram_addr: got 0x%h, expected one of 0x%h 0x%h 0x%h 0x%h",
                     $sampled(sdram_addr), $sampled(line_main), $sampled(line_snd),
                     $sampled(line_rom0), $sampled(line_rom1));
            errors++;
        end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !cs_seen |-> !(main_rom_ok || snd_ok || rom0_ok || rom1_ok || sdram_rd))
        else begin
            $display("An ok or sdram_rd went high before any client select");
            errors++;
        end

    a_hit_no_sdram: assert property (@(posedge clk) disable iff (rst)
        expect_hit |-> !sdram_rd)
        else begin
            $display("SDRAM read issued for a read that should hit the cached line");
            errors++;
        end

    a_hit_one_cycle: assert property (@(posedge clk) disable iff (rst)
        expect_hit && $rose(snd_cs) |=> snd_ok)
        else begin
            $display("Cache hit did not raise snd_ok on the next cycle");
            errors++;
        end

    a_one_xfer: assert property (@(posedge clk) disable iff (rst)
        $rose(sdram_rd) |-> !xfer_open)
        else begin
            $display("sdram_rd raised while another transfer was still pending");
            errors++;
        end

    // Each read starts on a rising edge and leaves one idle cycle behind it
    task automatic read_main(input logic [20:0] a);
        main_rom_cs   <= 1'b1;
        main_rom_addr <= a;
        do @(posedge clk); while (!main_rom_ok);
        main_rom_cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_snd(input logic [15:0] a);
        snd_cs   <= 1'b1;
        snd_addr <= a;
        do @(posedge clk); while (!snd_ok);
        snd_cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_rom0(input logic [19:0] a, input logic h);
        rom0_cs   <= 1'b1;
        rom0_addr <= a;
        rom0_half <= h;
        do @(posedge clk); while (!rom0_ok);
        rom0_cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_rom1(input logic [19:0] a, input logic h);
        rom1_cs   <= 1'b1;
        rom1_addr <= a;
        rom1_half <= h;
        do @(posedge clk); while (!rom1_ok);
        rom1_cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic log_test_result(input string name, input int err_before);
        if (errors == err_before) begin
            pass_count++;
            $display("Test %s: passed", name);
        end else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic mix_all_clients();
        logic [20:0] ma;
        logic [15:0] sa;
        logic [19:0] ga0, ga1;
        for (int r = 0; r < mix_rounds; r++) begin
            ma  = 21'($urandom);
            sa  = 16'($urandom);
            ga0 = 20'($urandom);
            ga1 = 20'($urandom);
            fork
                read_main(ma);
                read_snd(sa);
                read_rom0(ga0, ma[3]);
                read_rom1(ga1, sa[5]);
            join
        end
    endtask

    initial begin
        int err_before;
        void'($urandom(32'h3f30));
        rst           <= 1'b1;
        main_rom_cs   <= 1'b0;
        main_rom_addr <= '0;
        snd_cs        <= 1'b0;
        snd_addr      <= '0;
        rom0_cs       <= 1'b0;
        rom0_addr     <= '0;
        rom0_half     <= 1'b0;
        rom1_cs       <= 1'b0;
        rom1_addr     <= '0;
        rom1_half     <= 1'b0;
        expect_hit    <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        err_before = errors;
        repeat (10) @(posedge clk);     // Outputs must stay quiet
        log_test_result("reset_idle", err_before);

        err_before = errors;
        read_main(21'h00_0000);
        read_main(21'h00_0001);
        read_main(21'h00_0002);
        read_main(21'h00_0003);
        read_main(21'h01_2345);
        read_main(21'h1f_fffe);
        read_main(21'h1f_ffff);
        read_main(21'h00_0abc);
        log_test_result("main_reads", err_before);

        err_before = errors;
        read_snd(16'h1234);
        expect_hit <= 1'b1;             // Rest of the line is cached
        read_snd(16'h1235);
        read_snd(16'h1236);
        read_snd(16'h1237);
        expect_hit <= 1'b0;
        read_snd(16'hbeef);
        log_test_result("sound_bytes", err_before);

        err_before = errors;
        read_rom0(20'h0_1234, 1'b0);
        read_rom0(20'h0_1234, 1'b1);
        read_rom0(20'hf_ffff, 1'b0);
        read_rom0(20'hf_ffff, 1'b1);
        read_rom1(20'h0_1234, 1'b0);
        read_rom1(20'h0_1234, 1'b1);
        read_rom1(20'h8_0001, 1'b0);
        read_rom1(20'h8_0001, 1'b1);
        log_test_result("graphics_reads", err_before);

        err_before = errors;
        mix_all_clients();
        log_test_result("all_clients", err_before);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with a read still waiting for ok",
                 watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* dv/sdram_rd_model.sv */
// Behavioral SDRAM read port with random ack and rdy latency and address-derived data
`timescale 1ns/10ps

module sdram_rd_model (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                         sdram_rd,
    output logic                         sdram_ack,
    output logic                         sdram_rdy,
    output logic [rom_pkg::line_w-1:0]   data_read
);

    typedef enum logic [1:0] {
        mem_idle,
        mem_ack,    // Counting down to the ack pulse
        mem_rdy     // Counting down to the data pulse
    } mem_state_e;

    mem_state_e                   state;
    logic [2:0]                   cnt;
    logic [rom_pkg::sdram_aw-1:0] addr_q;

    // Stored word is the low address bits with a fixed pattern
    function automatic logic [15:0] mem_word(input logic [rom_pkg::sdram_aw-1:0] a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= mem_idle;
            cnt       <= 3'd0;
            addr_q    <= '0;
            sdram_ack <= 1'b0;
            sdram_rdy <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            sdram_rdy <= 1'b0;
            case (state)
                mem_idle: begin
                    if (sdram_rd) begin
                        addr_q <= sdram_addr;
                        cnt    <= 3'($urandom_range(2, 0));  // Ack 1 to 3 cycles on
                        state  <= mem_ack;
                    end
                end
                mem_ack: begin
                    if (cnt == 3'd0) begin
                        sdram_ack <= 1'b1;
                        cnt       <= 3'($urandom_range(5, 1));  // Rdy 2 to 6 after ack
                        state     <= mem_rdy;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                mem_rdy: begin
                    if (cnt == 3'd0) begin
                        sdram_rdy <= 1'b1;
                        data_read <= {mem_word(addr_q + 22'd1), mem_word(addr_q)};
                        state     <= mem_idle;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                default: state <= mem_idle;
            endcase
        end
    end

endmodule

/* design/rom_sdram_top.sv */
// ROM fetch top: client mapper, four cached bank requesters and SDRAM read arbiter
`timescale 1ns/10ps

module rom_sdram_top (
    input  logic        clk,
    input  logic        rst,
    // Main CPU
    input  logic        main_rom_cs,
    input  logic [20:0] main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    // Sound CPU
    input  logic        snd_cs,
    input  logic [15:0] snd_addr,
    output logic [ 7:0] snd_data,
    output logic        snd_ok,
    // Graphics
    input  logic        rom0_cs,
    input  logic [19:0] rom0_addr,
    input  logic        rom0_half,
    output logic [rom_pkg::line_w-1:0] rom0_data,
    output logic        rom0_ok,
    input  logic        rom1_cs,
    input  logic [19:0] rom1_addr,
    input  logic        rom1_half,
    output logic [rom_pkg::line_w-1:0] rom1_data,
    output logic        rom1_ok,
    // SDRAM read port
    output logic [rom_pkg::sdram_aw-1:0] sdram_addr,
    output logic                         sdram_rd,
    input  logic                         sdram_ack,
    input  logic                         sdram_rdy,
    input  logic [rom_pkg::line_w-1:0]   data_read
);

    logic [rom_pkg::num_banks-1:0]                        line_cs;
    logic [rom_pkg::num_banks-1:0][rom_pkg::sdram_aw-1:0] line_addr;
    logic [rom_pkg::num_banks-1:0][rom_pkg::line_w-1:0]   line_data;
    logic [rom_pkg::num_banks-1:0]                        line_ok;
    logic [rom_pkg::num_banks-1:0]                        bank_req;
    logic [rom_pkg::num_banks-1:0][rom_pkg::sdram_aw-1:0] bank_addr;
    logic [rom_pkg::num_banks-1:0]                        bank_gnt_done;
    logic [rom_pkg::line_w-1:0]                           line_in;

    rom_client_map u_map (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .main_rom_cs   ( main_rom_cs   ),
        .main_rom_addr ( main_rom_addr ),
        .main_rom_data ( main_rom_data ),
        .main_rom_ok   ( main_rom_ok   ),
        .snd_cs        ( snd_cs        ),
        .snd_addr      ( snd_addr      ),
        .snd_data      ( snd_data      ),
        .snd_ok        ( snd_ok        ),
        .rom0_cs       ( rom0_cs       ),
        .rom0_addr     ( rom0_addr     ),
        .rom0_half     ( rom0_half     ),
        .rom0_data     ( rom0_data     ),
        .rom0_ok       ( rom0_ok       ),
        .rom1_cs       ( rom1_cs       ),
        .rom1_addr     ( rom1_addr     ),
        .rom1_half     ( rom1_half     ),
        .rom1_data     ( rom1_data     ),
        .rom1_ok       ( rom1_ok       ),
        .line_data     ( line_data     ),
        .line_ok       ( line_ok       ),
        .line_cs       ( line_cs       ),
        .line_addr     ( line_addr     )
    );

    // Bank position follows rom_pkg::client_e
    for (genvar i = 0; i < rom_pkg::num_banks; i++) begin : gen_bank
        bank_romrq u_bank (
            .clk           ( clk              ),
            .rst           ( rst              ),
            .line_cs       ( line_cs[i]       ),
            .line_addr     ( line_addr[i]     ),
            .line_data     ( line_data[i]     ),
            .line_ok       ( line_ok[i]       ),
            .bank_gnt_done ( bank_gnt_done[i] ),
            .line_in       ( line_in          ),
            .bank_req      ( bank_req[i]      ),
            .bank_addr     ( bank_addr[i]     )
        );
    end

    sdram_rd_arbiter u_arb (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .bank_req      ( bank_req      ),
        .bank_addr     ( bank_addr     ),
        .bank_gnt_done ( bank_gnt_done ),
        .line_in       ( line_in       ),
        .sdram_addr    ( sdram_addr    ),
        .sdram_rd      ( sdram_rd      ),
        .sdram_ack     ( sdram_ack     ),
        .sdram_rdy     ( sdram_rdy     ),
        .data_read     ( data_read     )
    );

endmodule

/* design/sdram_rd_arbiter.sv */
// Round-robin arbiter from the bank requesters to the single SDRAM read port
`timescale 1ns/10ps

module sdram_rd_arbiter (
    input  logic                                                 clk,
    input  logic                                                 rst,
    // Bank requesters
    input  logic [rom_pkg::num_banks-1:0]                        bank_req,
    input  logic [rom_pkg::num_banks-1:0][rom_pkg::sdram_aw-1:0] bank_addr,
    output logic [rom_pkg::num_banks-1:0]                        bank_gnt_done,
    output logic [rom_pkg::line_w-1:0]                           line_in,
    // SDRAM read port
    output logic [rom_pkg::sdram_aw-1:0]                         sdram_addr,
    output logic                                                 sdram_rd,
    input  logic                                                 sdram_ack,
    input  logic                                                 sdram_rdy,
    input  logic [rom_pkg::line_w-1:0]                           data_read
);

    rom_pkg::arb_state_e state;

    rom_pkg::client_e sel;      // Bank of the transfer in flight
    rom_pkg::client_e last;     // Last bank served
    rom_pkg::client_e cand;
    rom_pkg::client_e pick;
    logic             found;

    logic [rom_pkg::num_banks-1:0] req_open;

    // A bank whose data is being returned drops its request next cycle
    assign req_open = bank_req & ~bank_gnt_done;

    // First open request after the last served bank
    always_comb begin
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= rom_pkg::num_banks; i++) begin
            cand = rom_pkg::client_e'(last + 2'(i));
            if (!found && req_open[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state         <= rom_pkg::arb_idle;
            sdram_rd      <= 1'b0;
            bank_gnt_done <= '0;
            sel           <= rom_pkg::cli_main;
            last          <= rom_pkg::cli_scr;  // Bank 0 goes first
        end else begin
            bank_gnt_done <= '0;
            case (state)
                rom_pkg::arb_idle: begin
                    if (found) begin
                        sel      <= pick;
                        sdram_rd <= 1'b1;
                        state    <= rom_pkg::arb_wait_ack;
                    end
                end
                rom_pkg::arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_rd <= 1'b0;
                        state    <= rom_pkg::arb_wait_rdy;
                    end
                end
                rom_pkg::arb_wait_rdy: begin
                    if (sdram_rdy) begin
                        bank_gnt_done[sel] <= 1'b1;
                        last               <= sel;
                        state              <= rom_pkg::arb_idle;
                    end
                end
                default: begin
                    sdram_rd <= 1'b0;
                    state    <= rom_pkg::arb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rom_pkg::arb_idle && found) begin
            sdram_addr <= bank_addr[pick];
        end
        if (state == rom_pkg::arb_wait_rdy && sdram_rdy) begin
            line_in <= data_read;   // Valid with the data_valid pulse
        end
    end

    // Only one transfer at a time on the SDRAM port
    a_rd_in_wait_ack: assert property (@(posedge clk) disable iff (rst)
        sdram_rd |-> state == rom_pkg::arb_wait_ack);

    a_one_done: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_gnt_done));

endmodule

/* romrq/bank_romrq.sv */
// One-line cached ROM requester for a single bank
`timescale 1ns/10ps

module bank_romrq (
    input  logic                         clk,
    input  logic                         rst,
    // Client side
    input  logic                         line_cs,
    input  logic [rom_pkg::sdram_aw-1:0] line_addr,
    output logic [rom_pkg::line_w-1:0]   line_data,
    output logic                         line_ok,
    // Arbiter side
    input  logic                         bank_gnt_done,  // Line on line_in this cycle
    input  logic [rom_pkg::line_w-1:0]   line_in,
    output logic                         bank_req,
    output logic [rom_pkg::sdram_aw-1:0] bank_addr
);

    rom_pkg::rq_state_e state;

    logic [rom_pkg::sdram_aw-1:0] tag;   // Line address of the cached data
    logic                         valid;
    logic                         hit;
    logic                         miss;
    logic                         fill;

    assign hit  = valid && (tag == line_addr);
    assign miss = (state == rom_pkg::rq_idle) && line_cs && !hit;
    assign fill = (state == rom_pkg::rq_wait_data) && bank_gnt_done;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= rom_pkg::rq_idle;
            valid    <= 1'b0;
            line_ok  <= 1'b0;
            bank_req <= 1'b0;
        end else begin
            case (state)
                rom_pkg::rq_idle: begin
                    line_ok <= line_cs && hit;  // Hit answers next cycle
                    if (miss) begin
                        bank_req <= 1'b1;
                        state    <= rom_pkg::rq_wait_gnt;
                    end
                end
                rom_pkg::rq_wait_gnt: begin
                    // The arbiter needs several cycles before any data can return
                    line_ok <= 1'b0;
                    state   <= rom_pkg::rq_wait_data;
                end
                rom_pkg::rq_wait_data: begin
                    line_ok <= 1'b0;
                    if (bank_gnt_done) begin
                        bank_req <= 1'b0;
                        valid    <= 1'b1;
                        // Client may have moved on while the fetch was out
                        line_ok  <= line_cs && (line_addr == bank_addr);
                        state    <= rom_pkg::rq_idle;
                    end
                end
                default: begin
                    line_ok  <= 1'b0;
                    bank_req <= 1'b0;
                    state    <= rom_pkg::rq_idle;
                end
            endcase
        end
    end

    // Line store and request address
    always_ff @(posedge clk) begin
        if (miss) begin
            bank_addr <= line_addr;
        end
        if (fill) begin
            tag       <= bank_addr;
            line_data <= line_in;
        end
    end

    // Request is held with a fixed address until its line comes back
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        bank_req && !bank_gnt_done |=> bank_req && $stable(bank_addr));

    // The arbiter only returns data to a bank that is waiting for it
    a_done_when_waiting: assert property (@(posedge clk) disable iff (rst)
        bank_gnt_done |-> bank_req && (state == rom_pkg::rq_wait_data));

endmodule

/* design/rom_client_map.sv */
// Client port adapter: line addresses with region offsets and word or byte select
`timescale 1ns/10ps

module rom_client_map (
    input  logic        clk,
    input  logic        rst,
    // Main CPU, 16-bit words
    input  logic        main_rom_cs,
    input  logic [20:0] main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    // Sound CPU, bytes
    input  logic        snd_cs,
    input  logic [15:0] snd_addr,
    output logic [ 7:0] snd_data,
    output logic        snd_ok,
    // Object and scroll graphics, full lines
    input  logic        rom0_cs,
    input  logic [19:0] rom0_addr,
    input  logic        rom0_half,
    output logic [rom_pkg::line_w-1:0] rom0_data,
    output logic        rom0_ok,
    input  logic        rom1_cs,
    input  logic [19:0] rom1_addr,
    input  logic        rom1_half,
    output logic [rom_pkg::line_w-1:0] rom1_data,
    output logic        rom1_ok,
    // Bank requester side
    input  logic [rom_pkg::num_banks-1:0][rom_pkg::line_w-1:0]   line_data,
    input  logic [rom_pkg::num_banks-1:0]                        line_ok,
    output logic [rom_pkg::num_banks-1:0]                        line_cs,
    output logic [rom_pkg::num_banks-1:0][rom_pkg::sdram_aw-1:0] line_addr
);

    logic       main_sel;   // High word of the line
    logic [1:0] snd_sel;    // Byte within the line

    assign line_cs[rom_pkg::cli_main] = main_rom_cs;
    assign line_cs[rom_pkg::cli_snd]  = snd_cs;
    assign line_cs[rom_pkg::cli_obj]  = rom0_cs;
    assign line_cs[rom_pkg::cli_scr]  = rom1_cs;

    // Even word address of the line holding the requested data
    assign line_addr[rom_pkg::cli_main] = rom_pkg::main_offset
                                        + {1'b0, main_rom_addr[20:1], 1'b0};
    assign line_addr[rom_pkg::cli_snd]  = rom_pkg::snd_offset + {7'd0, snd_addr[15:2], 1'b0};
    assign line_addr[rom_pkg::cli_obj]  = rom_pkg::obj_offset + {rom0_addr, rom0_half, 1'b0};
    assign line_addr[rom_pkg::cli_scr]  = rom_pkg::scr_offset + {rom1_addr, rom1_half, 1'b0};

    // Sampled alongside the registered ok of each bank
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            main_sel <= 1'b0;
            snd_sel  <= 2'd0;
        end else begin
            main_sel <= main_rom_addr[0];
            snd_sel  <= snd_addr[1:0];
        end
    end

    assign main_rom_data = main_sel ? line_data[rom_pkg::cli_main][31:16]
                                    : line_data[rom_pkg::cli_main][15:0];
    assign snd_data      = line_data[rom_pkg::cli_snd][{snd_sel, 3'b000} +: 8];  // Byte 0 is LSB
    assign rom0_data     = line_data[rom_pkg::cli_obj];
    assign rom1_data     = line_data[rom_pkg::cli_scr];

    assign main_rom_ok = line_ok[rom_pkg::cli_main];
    assign snd_ok      = line_ok[rom_pkg::cli_snd];
    assign rom0_ok     = line_ok[rom_pkg::cli_obj];
    assign rom1_ok     = line_ok[rom_pkg::cli_scr];

    // Pending sound request must keep its byte lane until the data comes back
    a_snd_sel_stable: assert property (@(posedge clk) disable iff (rst)
        snd_cs && !snd_ok && $past(snd_cs && !snd_ok) |=> $stable(snd_sel));

endmodule

/* common/rom_pkg.sv */
// ROM fetch sizes, SDRAM region offsets, client indices and FSM state enums
package rom_pkg;

    localparam int num_banks = 4;   // One requester per ROM client
    localparam int sdram_aw  = 22;  // SDRAM word address
    localparam int line_w    = 32;  // Two 16-bit words per read

    // Region base of each client in SDRAM, in 16-bit words
    localparam logic [sdram_aw-1:0] main_offset = 22'h00_0000;
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h10_0000;
    localparam logic [sdram_aw-1:0] obj_offset  = 22'h20_0000;
    localparam logic [sdram_aw-1:0] scr_offset  = 22'h30_0000;

    // Bank position of each client in the line vectors
    typedef enum logic [1:0] {
        cli_main = 2'd0,
        cli_snd  = 2'd1,
        cli_obj  = 2'd2,
        cli_scr  = 2'd3
    } client_e;

    // Bank requester
    typedef enum logic [1:0] {
        rq_idle,
        rq_wait_gnt,    // Request just raised, now visible to the arbiter
        rq_wait_data
    } rq_state_e;

    // SDRAM read arbiter
    typedef enum logic [1:0] {
        arb_idle,
        arb_wait_ack,
        arb_wait_rdy
    } arb_state_e;

endpackage
